// ==== verilog.f ====
+incdir+common
common/pwm_pkg.sv
pwm_channel/pwm_duty_sweep.sv
pwm_channel/pwm_channel.sv
src/pwm_top.sv
sim/tb_pwm.sv

// ==== run.sh ====
#!/bin/sh
# Build the PWM testbench with Verilator, run it, and look for the pass line.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot enter the project directory"
    exit 1
fi

verilator --binary --timing --assert -j 0 \
    -f verilog.f --top-module tb_pwm -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_pwm)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

printf '%s\n' "$sim_out" | grep -q "^TESTS PASSED$"
if [ $? -ne 0 ]; then
    echo "Pass line not found in simulation output"
    exit 1
fi

exit 0

// ==== sim/tb_pwm.sv ====
// Self-checking testbench for the PWM generator top level.
// A per-channel model is stepped on every rising edge and each output pin
// is compared with it on the falling edge. Runs under Verilator via run.sh.

`timescale 1ns/1ps
`default_nettype none

`include "pwm_params.svh"

module tb_pwm;

    import pwm_pkg::*;

    // Upper bounds of each test, in clock cycles
    localparam int RESET_CYC     = 40;
    localparam int FIXED_CYC     = 8 * 142;
    localparam int BREATH_UP_CYC = 300;
    localparam int BREATH_DN_CYC = 330;
    localparam int SWITCH_CYC    = 160;
    localparam int DUAL_CYC      = 4 * 202;
    localparam int TOTAL_CYC     = RESET_CYC + FIXED_CYC + BREATH_UP_CYC + BREATH_DN_CYC
                                   + SWITCH_CYC + DUAL_CYC;
    localparam int TIMEOUT_NS    = TOTAL_CYC * 8 + 2000;

    // Model state of one channel
    typedef struct packed {
        pwm_mode_t    mode_q;
        logic [31:0]  cnt;
        logic [31:0]  duty;
        logic         dir_down;
        logic         pwm;
    } model_t;

    logic                    clk_i;
    logic                    rstn_i;
    pwm_cfg_t                cfg [`PWM_NUM_CH];
    logic [`PWM_NUM_CH-1:0]  pwm_o;

    model_t  model [`PWM_NUM_CH];
    string   test_name;
    int      errors;
    int      checks;

    pwm_top uut (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .cfg    (cfg),
        .pwm_o  (pwm_o)
    );

    // 8 ns clock
    always #4 clk_i = ~clk_i;

    ////////////////////////////////////////////////////////////
    // Reference model and comparison
    ////////////////////////////////////////////////////////////

    // One clock edge of a channel, output is the new pwm bit
    function automatic model_t model_step(model_t s, pwm_cfg_t c);
        model_t       n;
        pwm_mode_t    m;
        logic         act;
        logic         breath;
        logic         enter;
        logic         last;
        longint       d;
        longint       lo;
        longint       hi;
        logic [31:0]  dsel;
        n = s;
        // Reserved code behaves as idle
        if (c.mode == PWM_FIXED || c.mode == PWM_BREATH) begin
            m = c.mode;
        end else begin
            m = PWM_IDLE;
        end
        act    = (m != PWM_IDLE);
        breath = (m == PWM_BREATH);
        enter  = act && (m != s.mode_q);
        last   = (s.cnt >= c.period);
        n.mode_q = m;
        if (!act) begin
            n.cnt = 32'd0;
        end else if (enter || last) begin
            n.cnt = 32'd1;
        end else begin
            n.cnt = s.cnt + 32'd1;
        end
        // Sweep bounds
        lo = (c.thr_a < c.thr_b) ? longint'({32'd0, c.thr_a}) : longint'({32'd0, c.thr_b});
        hi = (c.thr_a < c.thr_b) ? longint'({32'd0, c.thr_b}) : longint'({32'd0, c.thr_a});
        if (enter && breath) begin
            n.duty     = c.thr_a;
            n.dir_down = (c.thr_a >= c.thr_b);
        end else if (breath && last && (c.period != 32'd0)) begin
            if (s.dir_down) begin
                d = longint'({32'd0, s.duty}) - longint'({52'd0, c.step});
                if (d <= lo) begin
                    n.duty     = 32'(lo);
                    n.dir_down = 1'b0;
                end else begin
                    n.duty = 32'(d);
                end
            end else begin
                d = longint'({32'd0, s.duty}) + longint'({52'd0, c.step});
                if (d >= hi) begin
                    n.duty     = 32'(hi);
                    n.dir_down = 1'b1;
                end else begin
                    n.duty = 32'(d);
                end
            end
        end
        dsel  = breath ? n.duty : c.thr_a;
        n.pwm = act && (c.period != 32'd0) && (n.cnt <= dsel);
        return n;
    endfunction

    task automatic check_value(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s: expected %b, actual %b at %0t", name, exp, act, $time);
        end
    endtask

    // Model sees the same inputs as the DUT on each edge
    always @(posedge clk_i) begin
        for (int ch = 0; ch < `PWM_NUM_CH; ch++) begin
            if (!rstn_i) begin
                model[ch] = '0;
            end else begin
                model[ch] = model_step(model[ch], cfg[ch]);
            end
        end
    end

    // Outputs are settled half a cycle after the edge
    always @(negedge clk_i) begin
        for (int ch = 0; ch < `PWM_NUM_CH; ch++) begin
            check_value($sformatf("%s ch%0d", test_name, ch), model[ch].pwm, pwm_o[ch]);
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////

    function automatic pwm_cfg_t make_cfg(pwm_mode_t m, int p, int a, int b, int s);
        pwm_cfg_t c;
        c.mode   = m;
        c.period = p;
        c.thr_a  = a;
        c.thr_b  = b;
        c.step   = 12'(s);
        return c;
    endfunction

    // Returns 1 ns after the n-th rising edge, where inputs change
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk_i);
        #1;
    endtask

    task automatic set_both(input pwm_cfg_t c0, input pwm_cfg_t c1);
        cfg[0] = c0;
        cfg[1] = c1;
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        pwm_cfg_t idle_cfg;
        int       p;
        int       d;
        idle_cfg  = make_cfg(PWM_IDLE, 0, 0, 0, 0);
        clk_i     = 1'b0;
        rstn_i    = 1'b0;
        errors    = 0;
        checks    = 0;
        test_name = "reset";
        for (int ch = 0; ch < `PWM_NUM_CH; ch++) begin
            cfg[ch]   = idle_cfg;
            model[ch] = '0;
        end
        void'($urandom(32'ha21a_67cd));

        // Reset, idle, then reserved mode code
        wait_cycles(3);
        rstn_i = 1'b1;
        wait_cycles(10);
        test_name = "reserved";
        set_both(make_cfg(PWM_RSVD, 10, 5, 8, 1), make_cfg(PWM_RSVD, 3, 7, 1, 2));
        wait_cycles(20);
        set_both(idle_cfg, idle_cfg);
        wait_cycles(2);

        // Fixed duty, last pass with zero period
        test_name = "fixed";
        for (int i = 0; i < 8; i++) begin
            p = (i == 7) ? 0 : 1 + ($urandom % 40);
            d = $urandom % (p + 4);
            cfg[0] = make_cfg(PWM_FIXED, p, d, 0, 0);
            wait_cycles(3 * p + 20);
            cfg[0] = idle_cfg;
            wait_cycles(2);
        end

        // Rising sweep, step 5 does not divide 17
        test_name = "breath_up";
        cfg[0] = make_cfg(PWM_BREATH, 24, 3, 20, 5);
        wait_cycles(12 * 24);
        cfg[0] = idle_cfg;
        wait_cycles(2);

        // Falling sweep first
        test_name = "breath_down";
        cfg[0] = make_cfg(PWM_BREATH, 32, 30, 6, 7);
        wait_cycles(10 * 32);
        cfg[0] = idle_cfg;
        wait_cycles(2);

        // Idle mid-period, re-entry, fixed <-> breath switches
        test_name = "switch";
        cfg[0] = make_cfg(PWM_FIXED, 10, 4, 0, 0);
        wait_cycles(15);
        cfg[0] = idle_cfg;
        wait_cycles(3);
        cfg[0] = make_cfg(PWM_FIXED, 10, 4, 0, 0);
        wait_cycles(12);
        cfg[0] = make_cfg(PWM_BREATH, 12, 2, 9, 3);
        wait_cycles(30);
        cfg[0] = idle_cfg;
        wait_cycles(1);
        cfg[0] = make_cfg(PWM_BREATH, 12, 2, 9, 3);
        wait_cycles(30);
        cfg[0] = make_cfg(PWM_FIXED, 12, 5, 0, 0);
        wait_cycles(7);
        cfg[0] = make_cfg(PWM_BREATH, 12, 2, 9, 3);
        wait_cycles(20);
        cfg[0] = idle_cfg;
        wait_cycles(2);

        // Both channels with their own random setup
        test_name = "dual";
        for (int r = 0; r < 4; r++) begin
            for (int ch = 0; ch < `PWM_NUM_CH; ch++) begin
                p = 1 + ($urandom % 40);
                cfg[ch] = make_cfg(($urandom % 2) ? PWM_BREATH : PWM_FIXED, p,
                                   $urandom % (p + 4), $urandom % (p + 4),
                                   1 + ($urandom % 8));
            end
            wait_cycles(200);
            set_both(idle_cfg, idle_cfg);
            wait_cycles(2);
        end

        $display("Run complete: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // Watchdog sized from the test lengths
    initial begin
        #(TIMEOUT_NS);
        $display("Simulation timed out after %0d ns without finishing", TIMEOUT_NS);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/pwm_top.sv ====
// Top level of the multi-channel PWM generator.
// One configuration entry per channel in, one PWM pin per channel out.
// Each channel runs on its own, the channels share only clock and reset.

`timescale 1ns/1ps
`default_nettype none

`include "pwm_params.svh"

module pwm_top (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    // Static configuration, one entry per channel
    input  pwm_pkg::pwm_cfg_t       cfg [`PWM_NUM_CH],
    // PWM pins, bit n belongs to channel n
    output logic [`PWM_NUM_CH-1:0]  pwm_o
);

    ////////////////////////////////////////////////////////////
    // Channel instances
    ////////////////////////////////////////////////////////////

    genvar ch;

    generate
        for (ch = 0; ch < `PWM_NUM_CH; ch++) begin : g_ch
            // Counter, duty select and sweep of channel ch
            pwm_channel u_channel (
                .clk_i  (clk_i),
                .rstn_i (rstn_i),
                .cfg    (cfg[ch]),
                .pwm_o  (pwm_o[ch])
            );
        end
    endgenerate

endmodule

`default_nettype wire

// ==== pwm_channel/pwm_channel.sv ====
// One PWM channel with phase counter, duty selection and registered output.
// Every period is exactly cfg.period cycles and is high for the first D of them.
// D is thr_a in fixed mode and the sweep's duty in breathing mode.

`timescale 1ns/1ps
`default_nettype none

`include "pwm_params.svh"

module pwm_channel (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  pwm_pkg::pwm_cfg_t  cfg,
    output logic               pwm_o
);

    import pwm_pkg::*;

    // Mode after folding the reserved code onto idle
    pwm_mode_t              mode_eff;
    // Mode seen on the previous edge
    pwm_mode_t              mode_q;
    logic                   active;
    logic                   is_breath;
    logic                   entering;
    logic                   wrap;
    logic                   restart;
    logic                   period_end;
    logic [`PWM_CNT_W-1:0]  cnt_q;
    logic [`PWM_CNT_W-1:0]  cnt_d;
    logic [`PWM_CNT_W-1:0]  sweep_duty;
    logic [`PWM_CNT_W-1:0]  duty_sel;
    logic                   pwm_d;

    ////////////////////////////////////////////////////////////
    // Mode tracking and entry detection
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (cfg.mode)
            PWM_FIXED,
            PWM_BREATH: mode_eff = cfg.mode;
            // Reserved code runs as idle
            default:    mode_eff = PWM_IDLE;
        endcase
    end

    assign active    = (mode_eff != PWM_IDLE);
    assign is_breath = (mode_eff == PWM_BREATH);

    // Entry from idle, or a switch fixed <-> breath
    assign entering = active && (mode_eff != mode_q);

    // Sweep reloads only when breathing starts
    assign restart = entering && is_breath;

    ////////////////////////////////////////////////////////////
    // Phase counter, runs 1..period
    ////////////////////////////////////////////////////////////

    // Last cycle of the period or beyond it after the period shrank
    assign wrap = (cnt_q >= cfg.period);

    // Consumed only by the sweep in breathing mode
    // Zero period never ends and the duty stays put
    assign period_end = is_breath && !entering && wrap && (cfg.period != '0);

    always_comb begin
        if (!active) begin
            cnt_d = '0;
        end else if (entering || wrap) begin
            cnt_d = `PWM_CNT_W'(1);
        end else begin
            cnt_d = cnt_q + `PWM_CNT_W'(1);
        end
    end

    ////////////////////////////////////////////////////////////
    // Duty selection and output compare
    ////////////////////////////////////////////////////////////

    // Sweep output already holds the duty of the coming period
    assign duty_sel = is_breath ? sweep_duty : cfg.thr_a;

    // High while the phase is within the duty and the period is nonzero
    assign pwm_d = active && (cfg.period != '0) && (cnt_d <= duty_sel);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            mode_q <= PWM_IDLE;
            cnt_q  <= '0;
            pwm_o  <= 1'b0;
        end else begin
            mode_q <= mode_eff;
            cnt_q  <= cnt_d;
            pwm_o  <= pwm_d;
        end
    end

    ////////////////////////////////////////////////////////////
    // Breathing duty
    ////////////////////////////////////////////////////////////

    pwm_duty_sweep u_sweep (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .restart    (restart),
        .period_end (period_end),
        .thr_a      (cfg.thr_a),
        .thr_b      (cfg.thr_b),
        .step       (cfg.step),
        .duty       (sweep_duty)
    );

    // Idle or reserved code drops the pin and clears the phase on the next edge
    a_idle_low: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        ((cfg.mode == PWM_IDLE) || (cfg.mode == PWM_RSVD)) |=> (!pwm_o && (cnt_q == '0))
    ) else $error("pwm_o high or phase counter running one cycle after idle mode");

    // Phase stays inside a held, nonzero period
    a_cnt_range: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        ((cfg.period != '0) && $stable(cfg.period)) |-> (cnt_q <= cfg.period)
    ) else $error("phase counter beyond period");

endmodule

`default_nettype wire

// ==== pwm_channel/pwm_duty_sweep.sv ====
// Breathing duty of one PWM channel.
// Restart loads thr_a and picks the direction from the threshold order.
// Each period_end moves the duty one step, clamping and turning at the bounds.
// The duty output is the value for the next cycle, so a step is seen at once.

`timescale 1ns/1ps
`default_nettype none

`include "pwm_params.svh"

module pwm_duty_sweep (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  logic                    restart,
    input  logic                    period_end,
    input  logic [`PWM_CNT_W-1:0]   thr_a,
    input  logic [`PWM_CNT_W-1:0]   thr_b,
    input  logic [`PWM_STEP_W-1:0]  step,
    output logic [`PWM_CNT_W-1:0]   duty
);

    localparam int W = `PWM_CNT_W;

    logic [W-1:0]  duty_q;
    // 1 while sweeping down
    logic          dir_down_q;
    logic          dir_down_d;
    logic          start_down;
    logic [W-1:0]  lo_bound;
    logic [W-1:0]  hi_bound;
    // One extra bit to see wrap-around
    logic [W:0]    step_wide;
    logic [W:0]    sum_up;
    logic [W:0]    diff_down;
    logic [W-1:0]  stepped;
    logic          stepped_down;
    logic          in_bounds;

    ////////////////////////////////////////////////////////////
    // Bounds and start direction
    ////////////////////////////////////////////////////////////

    // Equal thresholds count as starting down
    assign start_down = (thr_a >= thr_b);
    assign lo_bound   = start_down ? thr_b : thr_a;
    assign hi_bound   = start_down ? thr_a : thr_b;

    ////////////////////////////////////////////////////////////
    // One step with clamping
    ////////////////////////////////////////////////////////////

    assign step_wide = {{(W + 1 - `PWM_STEP_W){1'b0}}, step};
    assign sum_up    = {1'b0, duty_q} + step_wide;
    assign diff_down = {1'b0, duty_q} - step_wide;

    always_comb begin
        if (dir_down_q) begin
            // Borrow out means we went below zero
            if (diff_down[W] || (diff_down[W-1:0] <= lo_bound)) begin
                stepped      = lo_bound;
                stepped_down = 1'b0;
            end else begin
                stepped      = diff_down[W-1:0];
                stepped_down = 1'b1;
            end
        end else begin
            // Wide compare also catches a carry out
            if (sum_up >= {1'b0, hi_bound}) begin
                stepped      = hi_bound;
                stepped_down = 1'b1;
            end else begin
                stepped      = sum_up[W-1:0];
                stepped_down = 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Duty and direction registers
    ////////////////////////////////////////////////////////////

    always_comb begin
        duty       = duty_q;
        dir_down_d = dir_down_q;
        if (restart) begin
            duty       = thr_a;
            dir_down_d = start_down;
        end else if (period_end) begin
            duty       = stepped;
            dir_down_d = stepped_down;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            duty_q     <= '0;
            dir_down_q <= 1'b0;
        end else begin
            duty_q     <= duty;
            dir_down_q <= dir_down_d;
        end
    end

    // Restart lands inside the bounds, and a step from inside stays inside
    assign in_bounds = (duty_q >= lo_bound) && (duty_q <= hi_bound);

    a_duty_in_bounds: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        (restart || (period_end && in_bounds)) |=>
            (!($stable(thr_a) && $stable(thr_b)) || in_bounds)
    ) else $error("breathing duty outside threshold bounds");

endmodule

`default_nettype wire

// ==== common/pwm_pkg.sv ====
// Shared types of the PWM generator: channel mode and the per-channel config.
// Compile before any RTL file; modules import it inside their body.

`default_nettype none

`include "pwm_params.svh"

package pwm_pkg;

    ////////////////////////////////////////////////////////////
    // Channel mode
    ////////////////////////////////////////////////////////////

    // Code 3 is reserved, channel treats it as idle
    typedef enum logic [1:0] {
        PWM_IDLE   = 2'd0,
        PWM_FIXED  = 2'd1,
        PWM_BREATH = 2'd2,
        PWM_RSVD   = 2'd3
    } pwm_mode_t;

    ////////////////////////////////////////////////////////////
    // Per-channel configuration, held as a level
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        // Operating mode
        pwm_mode_t               mode;
        // Period length in cycles, 0 keeps output low
        logic [`PWM_CNT_W-1:0]   period;
        // Fixed duty, also breathing start value
        logic [`PWM_CNT_W-1:0]   thr_a;
        // Other breathing bound
        logic [`PWM_CNT_W-1:0]   thr_b;
        // Duty change per period in breathing
        logic [`PWM_STEP_W-1:0]  step;
    } pwm_cfg_t;

endpackage

`default_nettype wire

// ==== common/pwm_params.svh ====
// Width and channel-count macros for the PWM generator.
// Included by the package and by every RTL file that sizes a port.

`ifndef PWM_PARAMS_SVH
`define PWM_PARAMS_SVH

////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////

// Periods, thresholds, phase counter and duty
`define PWM_CNT_W 32

// Breathing step size
`define PWM_STEP_W 12

////////////////////////////////////////////////////////////
// Instance count
////////////////////////////////////////////////////////////

// Channels generated in the top level
`define PWM_NUM_CH 2

`endif
